// File: include/pcxt_sysctl_macros.svh
// Rates, counts and option-word bit positions for the system-control glue
// All rates assume a single 50 MHz system clock
// Option-word positions follow the OSD status bit map of the core

`ifndef PCXT_SYSCTL_MACROS_SVH
`define PCXT_SYSCTL_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Clock rates
//////////////////////////////////////////////////////////////////////

`define SYSCLK_HZ 50_000_000
// Audio sample rate
`define AUDIO_HZ 44_100
// 8088 rate, 14.318 MHz over three
`define CPU_HZ 4_772_727

//////////////////////////////////////////////////////////////////////
// Reset sequencing
//////////////////////////////////////////////////////////////////////

`define RST_STRETCH_MAX 16'hFFFF
`define CPU_RESET_HOLD 42

//////////////////////////////////////////////////////////////////////
// Option decode
//////////////////////////////////////////////////////////////////////

// DIP switch patterns, MDA or CGA 80 columns
`define DIP_MDA 8'h3D
`define DIP_CGA 8'h2D
// Original 4:3 aspect
`define AR_DEFAULT_X 4
`define AR_DEFAULT_Y 3
// Low bit of each option field
`define STAT_SCALE_LO 1
`define STAT_MDA 4
`define STAT_AR_LO 8

`endif

// File: source/pcxt_sysctl_pkg.sv
// Shared types for the system-control glue
// Widths here must agree with the macro values in the rate header

`default_nettype none

package pcxt_sysctl_pkg;

	// OSD option word
	typedef logic [31:0] status_word_t;
	// Fractional rate accumulator
	typedef logic [31:0] acc_t;
	// Reset stretch and hold counter
	typedef logic [15:0] rst_count_t;
	// HDMI aspect value, bit 12 flags a scaled size
	typedef logic [12:0] aspect_t;
	// Scanline effect code
	typedef logic [1:0]  vga_sl_t;
	// Half of the DIP switch byte
	typedef logic [3:0]  dip_nibble_t;

	// Reset sequencer states
	typedef enum logic [1:0] {
		RS_STRETCH  = 2'd0,
		RS_CPU_HOLD = 2'd1,
		RS_RUN      = 2'd2
	} reset_state_t;

	// Single-cycle clock enables
	typedef struct packed {
		logic audio;
		logic cpu;
		logic periph;
	} strobes_t;

	// Active high resets
	typedef struct packed {
		logic sys;
		logic cpu;
	} resets_t;

	// Decoded video options
	typedef struct packed {
		vga_sl_t vga_sl;
		aspect_t arx;
		aspect_t ary;
	} video_cfg_t;

endpackage

`default_nettype wire

// File: source/rate_accumulator.sv
// Fractional divider, one pulse per SYSCLK_HZ of accumulated rate
// RATE_HZ must stay below SYSCLK_HZ so at most one wrap per cycle

`timescale 1ns/1ps
`default_nettype none

`include "pcxt_sysctl_macros.svh"

module rate_accumulator #(
	parameter int unsigned RATE_HZ = `AUDIO_HZ
) (
	input  wire  CLK_50M,
	input  wire  reset_wire,
	output logic pulse
);

	pcxt_sysctl_pkg::acc_t sum;
	pcxt_sysctl_pkg::acc_t sum_next;
	logic                  wrap;

	// Sum after this cycle's increment
	assign sum_next = sum + pcxt_sysctl_pkg::acc_t'(RATE_HZ);
	assign wrap     = (sum_next >= pcxt_sysctl_pkg::acc_t'(`SYSCLK_HZ));

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sum   <= '0;
			pulse <= 1'b0;
		end else begin
			pulse <= wrap;
			// Keep the remainder so the long-run rate is exact
			if (wrap) begin
				sum <= sum_next - pcxt_sysctl_pkg::acc_t'(`SYSCLK_HZ);
			end else begin
				sum <= sum_next;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/clock_strobe_gen.sv
// Audio, CPU and peripheral clock enables on the 50 MHz clock
// Strobes are raw here, gating with the resets happens downstream
// Peripheral enable is half the CPU rate, first one on the second CPU strobe

`timescale 1ns/1ps
`default_nettype none

`include "pcxt_sysctl_macros.svh"

module clock_strobe_gen (
	input  wire                       CLK_50M,
	input  wire                       reset_wire,
	output pcxt_sysctl_pkg::strobes_t raw
);

	logic audio_pulse;
	logic cpu_pulse;
	// High between odd and even CPU strobes
	logic periph_phase;

	//////////////////////////////////////////////////////////////////////
	// Rate accumulators
	//////////////////////////////////////////////////////////////////////

	// 44.1 kHz sample enable
	rate_accumulator #(
		.RATE_HZ (`AUDIO_HZ)
	) u_audio_acc (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.pulse      (audio_pulse)
	);

	// 4.77 MHz CPU enable
	rate_accumulator #(
		.RATE_HZ (`CPU_HZ)
	) u_cpu_acc (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.pulse      (cpu_pulse)
	);

	//////////////////////////////////////////////////////////////////////
	// Peripheral divide by two
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			periph_phase <= 1'b0;
		end else if (cpu_pulse) begin
			periph_phase <= ~periph_phase;
		end
	end

	// Fires together with every even CPU strobe
	assign raw = '{
		audio:  audio_pulse,
		cpu:    cpu_pulse,
		periph: cpu_pulse & periph_phase
	};

endmodule

`default_nettype wire

// File: source/reset_sequencer.sv
// Board reset stretch followed by a longer CPU reset hold
// System reset drops 65536 edges after reset_wire falls
// CPU reset drops CPU_RESET_HOLD plus two edges later
// reset_wire raises both resets at once at any time

`timescale 1ns/1ps
`default_nettype none

`include "pcxt_sysctl_macros.svh"

module reset_sequencer (
	input  wire                      CLK_50M,
	input  wire                      reset_wire,
	output pcxt_sysctl_pkg::resets_t resets
);

	pcxt_sysctl_pkg::reset_state_t state;
	pcxt_sysctl_pkg::rst_count_t   count;
	// System reset seen one cycle late by the CPU hold
	logic                          sys_q;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			state      <= pcxt_sysctl_pkg::RS_STRETCH;
			count      <= '0;
			sys_q      <= 1'b1;
			resets.sys <= 1'b1;
			resets.cpu <= 1'b1;
		end else begin
			sys_q <= resets.sys;

			case (state)
				// Both resets held until the counter tops out
				pcxt_sysctl_pkg::RS_STRETCH: begin
					if (count != pcxt_sysctl_pkg::rst_count_t'(`RST_STRETCH_MAX)) begin
						count <= count + 1'b1;
					end else begin
						resets.sys <= 1'b0;
						count      <= '0;
						state      <= pcxt_sysctl_pkg::RS_CPU_HOLD;
					end
				end

				// First cycle only re-registers the system reset
				pcxt_sysctl_pkg::RS_CPU_HOLD: begin
					if (!sys_q) begin
						if (count != pcxt_sysctl_pkg::rst_count_t'(`CPU_RESET_HOLD)) begin
							count <= count + 1'b1;
						end else begin
							resets.cpu <= 1'b0;
							state      <= pcxt_sysctl_pkg::RS_RUN;
						end
					end
				end

				// Released until the next board reset
				pcxt_sysctl_pkg::RS_RUN: begin
					resets.sys <= 1'b0;
					resets.cpu <= 1'b0;
				end

				// Unused encoding restarts the whole sequence
				default: begin
					state      <= pcxt_sysctl_pkg::RS_STRETCH;
					count      <= '0;
					resets.sys <= 1'b1;
					resets.cpu <= 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/core_control.sv
// Strobe gating, keyboard line synchronizers and option decode
// All outputs are registered, one cycle after their inputs
// PS/2 lines read low for the whole system reset

`timescale 1ns/1ps
`default_nettype none

`include "pcxt_sysctl_macros.svh"

module core_control (
	input  wire                           CLK_50M,
	input  wire                           reset_wire,
	input  wire pcxt_sysctl_pkg::strobes_t     raw,
	input  wire pcxt_sysctl_pkg::resets_t      resets,
	input  wire pcxt_sysctl_pkg::status_word_t status,
	input  wire logic [7:0]                    port_b,
	input  wire                                ps2_clk_in,
	input  wire                                ps2_data_in,
	output pcxt_sysctl_pkg::strobes_t          strobes,
	output pcxt_sysctl_pkg::video_cfg_t        video_cfg,
	output pcxt_sysctl_pkg::dip_nibble_t       port_c_lo,
	output logic                               ps2_clk,
	output logic                               ps2_data
);

	// Option fields
	logic [1:0]                     scale;
	logic [1:0]                     ar;
	logic                           mda_mode;
	logic [7:0]                     sw;
	pcxt_sysctl_pkg::video_cfg_t    video_next;
	pcxt_sysctl_pkg::dip_nibble_t   port_c_next;

	// First synchronizer stage
	logic ps2_clk_ff;
	logic ps2_data_ff;

	//////////////////////////////////////////////////////////////////////
	// Strobe gating
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			strobes <= '0;
		end else begin
			// Audio runs once the chipset is out of reset
			strobes.audio  <= raw.audio & ~resets.sys;
			// CPU and bus peripherals wait for the CPU reset
			strobes.cpu    <= raw.cpu & ~resets.cpu;
			strobes.periph <= raw.periph & ~resets.cpu;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// PS/2 keyboard synchronizers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			ps2_clk_ff  <= 1'b0;
			ps2_clk     <= 1'b0;
			ps2_data_ff <= 1'b0;
			ps2_data    <= 1'b0;
		end else if (resets.sys) begin
			// Held clear while the chipset is in reset
			ps2_clk_ff  <= 1'b0;
			ps2_clk     <= 1'b0;
			ps2_data_ff <= 1'b0;
			ps2_data    <= 1'b0;
		end else begin
			ps2_clk_ff  <= ps2_clk_in;
			ps2_clk     <= ps2_clk_ff;
			ps2_data_ff <= ps2_data_in;
			ps2_data    <= ps2_data_ff;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Option decode
	//////////////////////////////////////////////////////////////////////

	assign scale    = status[`STAT_SCALE_LO +: 2];
	assign ar       = status[`STAT_AR_LO +: 2];
	assign mda_mode = status[`STAT_MDA];

	// Scanline bits for CRT 25% and CRT 50%
	assign video_next.vga_sl = {scale == 2'd3, scale == 2'd2};

	// Zero selects the original 4:3 ratio
	// Other codes pick the custom aspect slots
	assign video_next.arx = (ar == 2'd0) ?
		pcxt_sysctl_pkg::aspect_t'(`AR_DEFAULT_X) :
		pcxt_sysctl_pkg::aspect_t'(ar - 2'd1);
	assign video_next.ary = (ar == 2'd0) ?
		pcxt_sysctl_pkg::aspect_t'(`AR_DEFAULT_Y) : '0;

	// Switch block by display adapter
	assign sw = mda_mode ? `DIP_MDA : `DIP_CGA;
	// Port B bit 3 swaps in the high switch nibble
	assign port_c_next = port_b[3] ? sw[7:4] : sw[3:0];

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			video_cfg <= '0;
			port_c_lo <= '0;
		end else begin
			video_cfg <= video_next;
			port_c_lo <= port_c_next;
		end
	end

endmodule

`default_nettype wire

// File: source/pcxt_sysctl.sv
// System-control top, everything on CLK_50M
// Strobes are clock enables, not clocks
// No handshakes, consumers sample levels and single-cycle strobes

`timescale 1ns/1ps
`default_nettype none

module pcxt_sysctl (
	input  wire                                CLK_50M,
	input  wire                                reset_wire,
	input  wire pcxt_sysctl_pkg::status_word_t status,
	input  wire logic [7:0]                    port_b,
	input  wire                                ps2_clk_in,
	input  wire                                ps2_data_in,
	output pcxt_sysctl_pkg::strobes_t          strobes,
	output pcxt_sysctl_pkg::resets_t           resets,
	output pcxt_sysctl_pkg::video_cfg_t        video_cfg,
	output pcxt_sysctl_pkg::dip_nibble_t       port_c_lo,
	output logic                               ps2_clk,
	output logic                               ps2_data
);

	// Ungated strobes from the accumulators
	pcxt_sysctl_pkg::strobes_t raw_strobes;

	clock_strobe_gen u_strobe_gen (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.raw        (raw_strobes)
	);

	reset_sequencer u_reset_seq (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.resets     (resets)
	);

	core_control u_core_ctrl (
		.CLK_50M     (CLK_50M),
		.reset_wire  (reset_wire),
		.raw         (raw_strobes),
		.resets      (resets),
		.status      (status),
		.port_b      (port_b),
		.ps2_clk_in  (ps2_clk_in),
		.ps2_data_in (ps2_data_in),
		.strobes     (strobes),
		.video_cfg   (video_cfg),
		.port_c_lo   (port_c_lo),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data)
	);

endmodule

`default_nettype wire

// File: dv/pcxt_sysctl_tb.sv
// Self-checking testbench for the system-control glue
// Run from the project root, option rows come from dv/option_vectors.txt
// Two full reset stretches make this a run of roughly 300k cycles

`timescale 1ns/1ps
`default_nettype none

`include "pcxt_sysctl_macros.svh"

module pcxt_sysctl_tb;

	localparam int     CLK_PERIOD     = 20;
	localparam longint STRETCH_CYCLES = longint'(`RST_STRETCH_MAX) + 1;
	localparam longint HOLD_CYCLES    = `CPU_RESET_HOLD + 2;
	localparam longint AUDIO_WINDOW   = 200_000;
	localparam longint CPU_WINDOW     = 20_000;
	localparam int     PS2_CYCLES     = 2_000;
	localparam int     MAX_VECTORS    = 64;
	// Both reset sequences plus strobe window and vector rows with ten percent margin
	localparam longint WATCHDOG_CYCLES = (2 * (STRETCH_CYCLES + HOLD_CYCLES) + AUDIO_WINDOW
		+ 4 * MAX_VECTORS + PS2_CYCLES) * 11 / 10;

	logic                          CLK_50M = 1'b0;
	logic                          reset_wire;
	pcxt_sysctl_pkg::status_word_t status;
	logic [7:0]                    port_b;
	logic                          ps2_clk_in;
	logic                          ps2_data_in;
	pcxt_sysctl_pkg::strobes_t     strobes;
	pcxt_sysctl_pkg::resets_t      resets;
	pcxt_sysctl_pkg::video_cfg_t   video_cfg;
	pcxt_sysctl_pkg::dip_nibble_t  port_c_lo;
	logic                          ps2_clk;
	logic                          ps2_data;

	integer     seed = 32'h0189_c78e;
	int         errors, checks, ps2_errors, ps2_checks, start, rows, fd, code;
	int         sys_low_run, audio_count, cpu_count, periph_count, periph_alone;
	longint     edge_n, sys_edge, cpu_edge, exp_audio, exp_cpu, exp_periph;
	// Driven {clk, data} pairs, newest first
	logic [1:0] hist [0:2];
	string      line;
	logic [31:0] v_status;
	logic [7:0]  v_port_b;
	logic [1:0]  v_sl;
	logic [12:0] v_arx, v_ary;
	logic [3:0]  v_pc;

	pcxt_sysctl dut (
		.CLK_50M     (CLK_50M),
		.reset_wire  (reset_wire),
		.status      (status),
		.port_b      (port_b),
		.ps2_clk_in  (ps2_clk_in),
		.ps2_data_in (ps2_data_in),
		.strobes     (strobes),
		.resets      (resets),
		.video_cfg   (video_cfg),
		.port_c_lo   (port_c_lo),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data)
	);

	always #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;

	task automatic verify(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			$display("[FAIL] %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	// Wraps over the first n edges after release
	function automatic longint wraps_after(input longint n, input longint rate);
		return (n * rate) / longint'(`SYSCLK_HZ);
	endfunction

	// New random PS/2 bits at the rising edge and checks at the falling edge
	task automatic tick();
		integer rnd;
		rnd = $random(seed);
		@(posedge CLK_50M);
		ps2_clk_in  <= rnd[0];
		ps2_data_in <= rnd[1];
		@(negedge CLK_50M);
		edge_n  = edge_n + 1;
		hist[2] = hist[1];
		hist[1] = hist[0];
		hist[0] = {rnd[0], rnd[1]};
		sys_low_run = resets.sys ? 0 : sys_low_run + 1;
		ps2_checks++;
		if (resets.sys) begin
			assert (!ps2_clk && !ps2_data) else begin
				$display("[FAIL] %0t ns: PS/2 lines high during system reset", $time);
				ps2_errors++;
			end
		end else if (sys_low_run >= 3) begin
			// Two-flop delay once the clear has flushed out
			assert ({ps2_clk, ps2_data} == hist[2]) else begin
				$display("[FAIL] %0t ns: PS/2 got %b expected %b", $time,
					{ps2_clk, ps2_data}, hist[2]);
				ps2_errors++;
			end
		end
	endtask

	task automatic release_reset();
		repeat (2) @(posedge CLK_50M);
		reset_wire <= 1'b0;
		edge_n = 0;
	endtask

	// Edge numbers of both reset falls and the audio strobes seen in the CPU hold
	task automatic run_reset_sequence(output longint sys_at, output longint cpu_at,
			output int audio_seen);
		int stray;
		stray      = 0;
		audio_seen = 0;
		while (resets.sys && edge_n < 2 * STRETCH_CYCLES) begin
			tick();
			if (resets.sys && (|strobes)) stray++;
		end
		sys_at = edge_n;
		verify(resets.cpu, "resets.cpu fell together with resets.sys");
		while (resets.cpu && edge_n < sys_at + 2 * HOLD_CYCLES) begin
			tick();
			if (resets.cpu && (strobes.cpu || strobes.periph)) stray++;
			if (strobes.audio) audio_seen++;
		end
		cpu_at = edge_n;
		verify(stray == 0, $sformatf("%0d strobes while held in reset", stray));
		verify(sys_at == STRETCH_CYCLES,
			$sformatf("resets.sys fell on edge %0d, expected %0d", sys_at, STRETCH_CYCLES));
		verify(cpu_at - sys_at == HOLD_CYCLES,
			$sformatf("resets.cpu fell %0d edges later, expected %0d",
			cpu_at - sys_at, HOLD_CYCLES));
	endtask

	task automatic check_option(input logic [31:0] s, input logic [7:0] b,
			input logic [1:0] sl, input logic [12:0] ax, input logic [12:0] ay,
			input logic [3:0] pc);
		@(posedge CLK_50M);
		status <= s;
		port_b <= b;
		@(negedge CLK_50M);
		// PS/2 inputs held over this edge
		hist[2] = hist[1];
		hist[1] = hist[0];
		tick();
		verify(video_cfg.vga_sl == sl && video_cfg.arx == ax && video_cfg.ary == ay
			&& port_c_lo == pc,
			$sformatf("status %h port_b %h gave sl %0d arx %0d ary %0d pc %h",
			s, b, video_cfg.vga_sl, video_cfg.arx, video_cfg.ary, port_c_lo));
	endtask

	initial begin
		reset_wire  = 1'b1;
		status      = '0;
		port_b      = '0;
		ps2_clk_in  = 1'b0;
		ps2_data_in = 1'b0;
		hist[0] = '0;
		hist[1] = '0;
		hist[2] = '0;
		release_reset();

		////////////////////////////////////////////////////////////////////
		// Test 1 checks the reset sequence then a mid-run board reset
		start = errors;
		run_reset_sequence(sys_edge, cpu_edge, audio_count);
		repeat (10) tick();
		// Board reset lands on an edge that raises strobes.cpu
		while (wraps_after(edge_n, `CPU_HZ) == wraps_after(edge_n - 1, `CPU_HZ)) begin
			tick();
		end
		@(posedge CLK_50M);
		reset_wire <= 1'b1;
		// Sampled before the next edge so only the async path can act
		@(negedge CLK_50M);
		verify(resets.sys && resets.cpu, "reset_wire did not raise both resets at once");
		verify(strobes == 3'b000, "strobes not cleared by reset_wire");
		release_reset();
		run_reset_sequence(sys_edge, cpu_edge, audio_count);
		$display("test 1 reset sequence: %0d errors", errors - start);

		////////////////////////////////////////////////////////////////////
		// Tests 2 and 3 share one window after the second release
		start        = errors;
		cpu_count    = 0;
		periph_count = 0;
		periph_alone = 0;
		while (edge_n < sys_edge + AUDIO_WINDOW) begin
			tick();
			if (strobes.audio) audio_count++;
			if (edge_n <= cpu_edge + CPU_WINDOW) begin
				if (strobes.cpu) cpu_count++;
				if (strobes.periph) periph_count++;
				if (strobes.periph && !strobes.cpu) periph_alone++;
			end
		end
		// Output register lags the raw wrap by one edge
		exp_audio = wraps_after(sys_edge + AUDIO_WINDOW - 1, `AUDIO_HZ)
			- wraps_after(sys_edge - 1, `AUDIO_HZ);
		verify(audio_count == exp_audio,
			$sformatf("audio strobes %0d, expected %0d", audio_count, exp_audio));
		$display("test 2 audio strobes: %0d errors", errors - start);

		start      = errors;
		exp_cpu    = wraps_after(cpu_edge + CPU_WINDOW - 1, `CPU_HZ);
		exp_periph = exp_cpu / 2 - wraps_after(cpu_edge - 1, `CPU_HZ) / 2;
		exp_cpu    = exp_cpu - wraps_after(cpu_edge - 1, `CPU_HZ);
		verify(cpu_count == exp_cpu,
			$sformatf("cpu strobes %0d, expected %0d", cpu_count, exp_cpu));
		verify(periph_count == exp_periph,
			$sformatf("periph strobes %0d, expected %0d", periph_count, exp_periph));
		verify(periph_alone == 0, $sformatf("%0d periph strobes without cpu", periph_alone));
		$display("test 3 cpu and periph strobes: %0d errors", errors - start);

		////////////////////////////////////////////////////////////////////
		// Test 4 walks the option decode rows
		start = errors;
		rows  = 0;
		fd    = $fopen("dv/option_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/option_vectors.txt for reading");
			errors++;
		end else begin
			while (!$feof(fd) && rows < MAX_VECTORS) begin
				line = "";
				code = $fgets(line, fd);
				// Comment and blank lines do not scan as six fields
				if (code > 0 && $sscanf(line, "%h %h %h %h %h %h", v_status, v_port_b,
						v_sl, v_arx, v_ary, v_pc) == 6) begin
					check_option(v_status, v_port_b, v_sl, v_arx, v_ary, v_pc);
					rows++;
				end
			end
			$fclose(fd);
		end
		verify(rows > 0, "no option rows were read");
		$display("test 4 option decode, %0d rows: %0d errors", rows, errors - start);

		////////////////////////////////////////////////////////////////////
		// Test 5 drives only the PS/2 lines
		repeat (PS2_CYCLES) tick();
		$display("test 5 ps2 synchronizers, %0d checks: %0d errors", ps2_checks, ps2_errors);

		$display("summary: %0d checks, %0d errors", checks + ps2_checks, errors + ps2_errors);
		if (errors == 0 && ps2_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the run did not complete",
			WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/option_vectors.txt
# status port_b vga_sl arx ary port_c_lo
# all columns hex, expected decode one cycle after the row is applied
00000000 00 0 0004 0003 d
00000000 08 0 0004 0003 2
00000010 08 0 0004 0003 3
00000010 00 0 0004 0003 d
00000002 00 0 0004 0003 d
00000004 00 1 0004 0003 d
00000006 00 2 0004 0003 d
00000100 00 0 0000 0000 d
00000200 00 0 0001 0000 d
00000300 08 0 0002 0000 2
00000316 08 2 0002 0000 3
ffffffff ff 2 0002 0000 3
fffffce9 f7 0 0004 0003 d
12345678 0c 0 0001 0000 3
0000fe04 08 1 0001 0000 2
00000115 00 1 0000 0000 d

// File: build.f
+incdir+include
source/pcxt_sysctl_pkg.sv
source/rate_accumulator.sv
source/clock_strobe_gen.sv
source/reset_sequencer.sv
source/core_control.sv
source/pcxt_sysctl.sv
dv/pcxt_sysctl_tb.sv

// File: Bender.yml
package:
  name: pcxt_sysctl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/pcxt_sysctl_pkg.sv
      - source/rate_accumulator.sv
      - source/clock_strobe_gen.sv
      - source/reset_sequencer.sv
      - source/core_control.sv
      - source/pcxt_sysctl.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/pcxt_sysctl_tb.sv
